// File: src.f
+incdir+sim
logic/crc_pkg.sv
logic/frame_pkg.sv
logic/lane_decode.sv
logic/crc_engine.sv
logic/fcs_result.sv
logic/crc32_tx.sv
sim/crc32_tx_tb.sv

// File: Bender.yml
package:
  name: crc32_tx

sources:
  - files:
      - logic/crc_pkg.sv
      - logic/frame_pkg.sv
      - logic/lane_decode.sv
      - logic/crc_engine.sv
      - logic/fcs_result.sv
      - logic/crc32_tx.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/crc32_tx_tb.sv

// File: sim/crc_model.svh
`ifndef CRC_MODEL_SVH
`define CRC_MODEL_SVH

typedef logic [7:0] byte_t;

// Generator in normal bit order, the hardware uses its mirror image
localparam logic [31:0] model_poly = 32'h04c11db7;

function automatic logic [31:0] mirror32(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
        r[i] = v[31-i];
    return r;
endfunction

// MSB first shift register, each byte fed LSB first as it leaves on the wire
function automatic logic [31:0] reference_crc(input byte_t data[$]);
    logic [31:0] r;
    logic        fb;
    r = 32'hffffffff;
    foreach (data[n])
    begin
        for (int b = 0; b < 8; b++)
        begin
            fb = r[31] ^ data[n][b];
            r  = {r[30:0], 1'b0};
            if (fb)
                r = r ^ model_poly;
        end
    end
    return ~mirror32(r);  // Back to reflected order, then invert
endfunction

task automatic random_bytes(output byte_t data[$], input int count);
    data = {};
    for (int i = 0; i < count; i++)
        data.push_back(byte_t'($random(seed)));
endtask

// Frame of 1 to words_max words, the final word carries 1 to lanes bytes
task automatic random_frame(output byte_t data[$], input int words_max);
    int words;
    int tail;
    words = 1 + ($unsigned($random(seed)) % words_max);
    tail  = 1 + ($unsigned($random(seed)) % lanes);
    random_bytes(data, (words - 1) * lanes + tail);
endtask

`endif

// File: sim/crc32_tx_tb.sv
module crc32_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int lanes = 8;
    localparam int burst_frames = 30;
    localparam int gap_frames = 12;
    localparam int max_words = 20;
    localparam int max_gap = 3;

    // Upper bounds on traffic, used for the watchdog
    localparam int total_words = 2 + 24 + 18 + (4 + burst_frames * max_words)
                                 + gap_frames * max_words;
    localparam int total_frames = 1 + 16 + 6 + 4 + burst_frames + gap_frames;
    localparam int idle_max = 8 + 10 + 6 * 5 + 6 * 9 + gap_frames * max_words * max_gap;
    localparam int cycle_limit = total_words + 3 * total_frames + idle_max + 50;

    logic                  tx_clk;
    logic                  tx_rstb;
    logic [lanes*8-1:0]    packet_in;
    logic [lanes-1:0]      keep;
    logic                  valid_in;
    logic                  last;
    logic [31:0]           crc32_out;
    logic                  crc32_valid;

    integer      seed = 32'h44eb;
    int          cyc = 0;           // Rising edges seen so far
    int          error_count = 0;
    int          base_errors = 0;
    int          result_count = 0;

    logic [31:0] exp_crc_q[$];
    int          exp_due_q[$];
    logic [31:0] head_crc = '0;
    int          head_due = 0;
    logic        head_ok = 1'b0;
    logic [31:0] held_out = '0;

    `include "crc_model.svh"

    crc32_tx #(
        .lanes (lanes)
    ) dut (
        .tx_clk      (tx_clk),
        .tx_rstb     (tx_rstb),
        .packet_in   (packet_in),
        .keep        (keep),
        .valid_in    (valid_in),
        .last        (last),
        .crc32_out   (crc32_out),
        .crc32_valid (crc32_valid)
    );

    initial
    begin
        tx_clk = 1'b0;
        forever
            #4 tx_clk = ~tx_clk;
    end

    always @(posedge tx_clk)
    begin
        cyc = cyc + 1;
        if (cyc >= cycle_limit)
        begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cyc, exp_crc_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    // Retire the expected result that this pulse answers
    always @(posedge tx_clk)
    begin
        held_out = crc32_out;
        if (tx_rstb && crc32_valid && exp_crc_q.size() > 0)
        begin
            void'(exp_crc_q.pop_front());
            void'(exp_due_q.pop_front());
            result_count++;
            refresh_head();
        end
    end

    a_reset_quiet: assert property (
        @(posedge tx_clk) !tx_rstb && cyc > 0 |-> !crc32_valid && crc32_out == '0
    ) else
    begin
        error_count++;
        $display("[FAIL] %0t crc32_valid got %0b expected 0, crc32_out got %08h expected %08h",
                 $time, $sampled(crc32_valid), $sampled(crc32_out), 32'h0);
    end

    a_reset_value: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        result_count == 0 && !crc32_valid |-> crc32_out == '0
    ) else
    begin
        error_count++;
        $display("[FAIL] %0t crc32_out got %08h expected %08h", $time,
                 $sampled(crc32_out), 32'h0);
    end

    a_pulse_expected: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        crc32_valid |-> head_ok
    ) else
    begin
        error_count++;
        $display("%0t: crc32_valid pulsed with no frame outstanding", $time);
    end

    a_crc_value: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        crc32_valid && head_ok |-> crc32_out == head_crc
    ) else
    begin
        error_count++;
        $display("[FAIL] %0t crc32_out got %08h expected %08h", $time,
                 $sampled(crc32_out), $sampled(head_crc));
    end

    a_pulse_cycle: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        crc32_valid && head_ok |-> cyc == head_due
    ) else
    begin
        error_count++;
        $display("[FAIL] %0t crc32_valid cycle got %0d expected %0d", $time,
                 $sampled(cyc), $sampled(head_due));
    end

    a_pulse_missing: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        head_ok && cyc == head_due |-> crc32_valid
    ) else
    begin
        error_count++;
        $display("%0t: no crc32_valid pulse in cycle %0d", $time, $sampled(head_due));
    end

    a_out_hold: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        !crc32_valid |-> crc32_out == held_out
    ) else
    begin
        error_count++;
        $display("[FAIL] %0t crc32_out got %08h expected %08h", $time,
                 $sampled(crc32_out), $sampled(held_out));
    end

    function automatic void refresh_head();
        head_ok = exp_crc_q.size() > 0;
        if (head_ok)
        begin
            head_crc = exp_crc_q[0];
            head_due = exp_due_q[0];
        end
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge tx_clk);
            valid_in = 1'b0;
            last     = 1'b0;
            keep     = '0;
        end
    endtask

    // Words go out lane 0 first, unused lanes of the tail carry junk
    task automatic send_frame(input byte_t data[$], input logic [31:0] crc, input int gap_max);
        int n_words;
        int gap;
        n_words = (data.size() + lanes - 1) / lanes;
        for (int w = 0; w < n_words; w++)
        begin
            if (w > 0 && gap_max > 0)
            begin
                gap = $unsigned($random(seed)) % (gap_max + 1);
                idle_cycles(gap);
            end
            @(negedge tx_clk);
            keep = '0;
            for (int i = 0; i < lanes; i++)
            begin
                packet_in[i*8 +: 8] = byte_t'($random(seed));
                if (w * lanes + i < data.size())
                begin
                    packet_in[i*8 +: 8] = data[w*lanes+i];
                    keep[i] = 1'b1;
                end
            end
            valid_in = 1'b1;
            last     = (w == n_words - 1);
        end
        exp_crc_q.push_back(crc);
        exp_due_q.push_back(cyc + 3);  // Pulse is sampled three edges after last
        refresh_head();
    endtask

    task automatic report_test(input string name, input int frames);
        idle_cycles(1);
        while (exp_crc_q.size() != 0)
            idle_cycles(1);
        idle_cycles(4);
        $display("%-20s frames %0d  errors %0d", name, frames, error_count - base_errors);
        base_errors = error_count;
    endtask

    initial
    begin
        byte_t data[$];
        tx_rstb   = 1'b0;
        packet_in = '0;
        keep      = '0;
        valid_in  = 1'b0;
        last      = 1'b0;
        repeat (8) @(negedge tx_clk);
        tx_rstb = 1'b1;

        idle_cycles(10);
        report_test("reset state", 0);

        data = {8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
        send_frame(data, 32'hcbf43926, 0);
        report_test("check value", 1);

        for (int k = 1; k <= lanes; k++)
        begin
            random_bytes(data, k);
            send_frame(data, reference_crc(data), 0);
            random_bytes(data, lanes + k);
            send_frame(data, reference_crc(data), 0);
        end
        report_test("final word lengths", 16);

        for (int f = 0; f < 6; f++)
        begin
            random_frame(data, 3);
            send_frame(data, reference_crc(data), 0);
            idle_cycles(5);  // Output must hold here
        end
        report_test("latency and hold", 6);

        for (int f = 0; f < 4; f++)
        begin
            random_frame(data, 1);
            send_frame(data, reference_crc(data), 0);
        end
        for (int f = 0; f < burst_frames; f++)
        begin
            random_frame(data, max_words);
            send_frame(data, reference_crc(data), 0);
        end
        report_test("back to back", 4 + burst_frames);

        for (int f = 0; f < gap_frames; f++)
        begin
            random_frame(data, max_words);
            send_frame(data, reference_crc(data), max_gap);
        end
        report_test("gaps inside frames", gap_frames);

        if (exp_crc_q.size() != 0)
            $display("%0d expected results never appeared", exp_crc_q.size());
        $display("Results checked %0d, errors %0d", result_count, error_count);
        if (error_count == 0 && exp_crc_q.size() == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: logic/crc32_tx.sv
module crc32_tx #(
    parameter int lanes = 8
) (
    input  logic                                 tx_clk,
    input  logic                                 tx_rstb,
    input  logic [lanes*frame_pkg::lane_w-1:0]   packet_in,
    input  logic [lanes-1:0]                     keep,
    input  logic                                 valid_in,
    input  logic                                 last,
    output crc_pkg::crc_t                        crc32_out,
    output logic                                 crc32_valid
);
    import crc_pkg::*;
    import frame_pkg::*;

    logic                     dec_valid;
    logic                     dec_first;
    logic                     dec_last;
    byte_cnt_t                dec_count;
    logic [lanes*lane_w-1:0]  dec_data;

    crc_t                     crc_state;
    logic                     crc_done;

    lane_decode #(
        .lanes (lanes)
    ) u_decode (
        .tx_clk    (tx_clk),
        .tx_rstb   (tx_rstb),
        .packet_in (packet_in),
        .keep      (keep),
        .valid_in  (valid_in),
        .last      (last),
        .dec_valid (dec_valid),
        .dec_first (dec_first),
        .dec_last  (dec_last),
        .dec_count (dec_count),
        .dec_data  (dec_data)
    );

    crc_engine #(
        .lanes (lanes)
    ) u_engine (
        .tx_clk    (tx_clk),
        .tx_rstb   (tx_rstb),
        .dec_valid (dec_valid),
        .dec_first (dec_first),
        .dec_last  (dec_last),
        .dec_count (dec_count),
        .dec_data  (dec_data),
        .crc_state (crc_state),
        .crc_done  (crc_done)
    );

    fcs_result u_result (
        .tx_clk      (tx_clk),
        .tx_rstb     (tx_rstb),
        .crc_state   (crc_state),
        .crc_done    (crc_done),
        .crc32_out   (crc32_out),
        .crc32_valid (crc32_valid)
    );

endmodule

// File: logic/fcs_result.sv
module fcs_result (
    input  logic          tx_clk,
    input  logic          tx_rstb,
    input  crc_pkg::crc_t crc_state,
    input  logic          crc_done,
    output crc_pkg::crc_t crc32_out,
    output logic          crc32_valid
);
    import crc_pkg::*;

    // Latch the finished FCS, hold it until the next frame ends
    always_ff @(posedge tx_clk or negedge tx_rstb)
    begin
        if (!tx_rstb)
        begin
            crc32_out   <= '0;
            crc32_valid <= 1'b0;
        end
        else
        begin
            crc32_valid <= crc_done;  // One cycle strobe
            if (crc_done)
                crc32_out <= crc_state ^ crc_final_xor;
        end
    end

endmodule

// File: logic/crc_engine.sv
module crc_engine #(
    parameter int lanes = 8
) (
    input  logic                                 tx_clk,
    input  logic                                 tx_rstb,
    input  logic                                 dec_valid,
    input  logic                                 dec_first,
    input  logic                                 dec_last,
    input  crc_pkg::byte_cnt_t                   dec_count,
    input  logic [lanes*frame_pkg::lane_w-1:0]   dec_data,
    output crc_pkg::crc_t                        crc_state,
    output logic                                 crc_done
);
    import crc_pkg::*;
    import frame_pkg::*;

    crc_t crc_start;
    crc_t crc_next;

    // One byte through the reflected shift register, LSB first
    function automatic crc_t crc_byte(input crc_t crc, input lane_t data);
        crc_t c;
        c = crc ^ crc_t'(data);
        for (int b = 0; b < lane_w; b++)
        begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_start = dec_first ? crc_seed : crc_state;  // Reseed per frame

    // Fold lanes in wire order, stopping at the byte count
    always_comb
    begin
        crc_next = crc_start;
        for (int i = 0; i < lanes; i++)
        begin
            if (byte_cnt_t'(i) < dec_count)
                crc_next = crc_byte(crc_next, dec_data[i*lane_w +: lane_w]);
        end
    end

    // Holds across idle cycles inside a frame
    always_ff @(posedge tx_clk)
    begin
        if (dec_valid)
            crc_state <= crc_next;
    end

    always_ff @(posedge tx_clk or negedge tx_rstb)
    begin
        if (!tx_rstb)
            crc_done <= 1'b0;
        else
            crc_done <= dec_valid && dec_last;
    end

    // Back to back results only when the second frame is a single word
    a_done_spacing: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        crc_done ##1 crc_done |-> $past(dec_first)
    );

endmodule

// File: logic/lane_decode.sv
module lane_decode #(
    parameter int lanes = 8
) (
    input  logic                                 tx_clk,
    input  logic                                 tx_rstb,
    input  logic [lanes*frame_pkg::lane_w-1:0]   packet_in,
    input  logic [lanes-1:0]                     keep,
    input  logic                                 valid_in,
    input  logic                                 last,
    output logic                                 dec_valid,
    output logic                                 dec_first,
    output logic                                 dec_last,
    output crc_pkg::byte_cnt_t                   dec_count,
    output logic [lanes*frame_pkg::lane_w-1:0]   dec_data
);
    import crc_pkg::*;
    import frame_pkg::*;

    frame_state_e frame_state;
    byte_cnt_t    keep_count;

    // Population count of the byte enables
    always_comb
    begin
        keep_count = '0;
        for (int i = 0; i < lanes; i++)
        begin
            keep_count = keep_count + byte_cnt_t'(keep[i]);
        end
    end

    // A frame opens on any valid word and closes on last
    always_ff @(posedge tx_clk or negedge tx_rstb)
    begin
        if (!tx_rstb)
            frame_state <= frame_idle;
        else if (valid_in)
            frame_state <= last ? frame_idle : frame_body;
    end

    always_ff @(posedge tx_clk or negedge tx_rstb)
    begin
        if (!tx_rstb)
        begin
            dec_valid <= 1'b0;
            dec_first <= 1'b0;
            dec_last  <= 1'b0;
        end
        else
        begin
            dec_valid <= valid_in;
            dec_first <= valid_in && (frame_state == frame_idle);
            dec_last  <= valid_in && last;
        end
    end

    always_ff @(posedge tx_clk)
    begin
        if (valid_in)
        begin
            dec_count <= keep_count;
            dec_data  <= packet_in;
        end
    end

    // Enabled lanes start at lane 0 with no holes
    a_keep_contiguous: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        valid_in |-> (keep != '0) && ((keep & (keep + 1'b1)) == '0)
    );

    // Short words only at the end of a frame
    a_keep_full_body: assert property (
        @(posedge tx_clk) disable iff (!tx_rstb)
        valid_in && !last |-> &keep
    );

endmodule

// File: logic/frame_pkg.sv
package frame_pkg;

    localparam int lane_w = 8;  // Bits per byte lane

    typedef logic [lane_w-1:0] lane_t;

    // Whether a frame is open on the input stream
    typedef enum logic
    {
        frame_idle = 1'b0,
        frame_body = 1'b1
    } frame_state_e;

endpackage

// File: logic/crc_pkg.sv
package crc_pkg;

    // Running CRC register and final FCS value
    typedef logic [31:0] crc_t;

    // Bytes carried by one word, 0 up to 8
    typedef logic [3:0] byte_cnt_t;

    // Reflected form of 04C11DB7, LSB first on the wire
    localparam crc_t crc_poly = 32'hedb88320;

    localparam crc_t crc_seed = 32'hffffffff;       // Preset at frame start
    localparam crc_t crc_final_xor = 32'hffffffff;  // Ones complement of the result

endpackage
